// ==== Bender.yml ====
package:
  name: strip_link_rx

sources:
  - logic/strip_link_pkg.sv
  - logic/word_gatherer.sv
  - logic/frame_aligner.sv
  - logic/frame_sync_fsm.sv
  - logic/packet_serializer.sv
  - logic/strip_link_rx.sv

  - target: test
    files:
      - test/strip_link_rx_asserts.sv
      - test/strip_link_rx_tb.sv

// ==== logic/frame_aligner.sv ====
`timescale 1ns/10ps
`default_nettype none

module frame_aligner (
    input  wire                             clk160,
    input  wire                             system_reset_r2,
    input  wire strip_link_pkg::frame_t     raw_frame,
    input  wire                             frame_strobe,
    input  wire strip_link_pkg::align_pos_t align_pos,
    output strip_link_pkg::frame_t          aligned_frame,
    output logic                            aligned_strobe
);

    localparam int frame_width = strip_link_pkg::FRAME_WIDTH;

    strip_link_pkg::frame_t prev_frame;
    logic [2*frame_width-1:0] frame_pair;
    logic [7:0] sel_base;

    // previous frame on top, current below it
    assign frame_pair = {prev_frame, raw_frame};

    // window top bit is prev_frame[align_pos], so the low end sits one above it
    assign sel_base = {1'b0, align_pos} + 8'd1;

    always_ff @(posedge clk160) begin
        if (frame_strobe) begin
            prev_frame    <= raw_frame;
            aligned_frame <= frame_pair[sel_base +: frame_width];
        end
    end

    always_ff @(posedge clk160) begin
        if (system_reset_r2) begin
            aligned_strobe <= 1'b0;
        end else begin
            aligned_strobe <= frame_strobe;
        end
    end

endmodule

`default_nettype wire

// ==== logic/frame_sync_fsm.sv ====
`timescale 1ns/10ps
`default_nettype none

module frame_sync_fsm #(
    parameter int lock_good_count = 509,
    parameter int hunt_err_limit  = 5,
    parameter int lock_err_limit  = 16
) (
    input  wire                              clk160,
    input  wire                              system_reset_r2,
    input  wire strip_link_pkg::frame_t      aligned_frame,
    input  wire                              aligned_strobe,
    output strip_link_pkg::align_pos_t       align_pos,
    output strip_link_pkg::link_state_t      link_state,
    output strip_link_pkg::good_count_t      good_count,
    output strip_link_pkg::err_count_t       err_count,
    output logic                             locked
);

    localparam int packet_width = strip_link_pkg::PACKET_WIDTH;
    localparam int header_width = strip_link_pkg::HEADER_WIDTH;

    localparam strip_link_pkg::good_count_t good_target = 9'(lock_good_count);
    localparam strip_link_pkg::err_count_t hunt_err_max = 5'(hunt_err_limit);
    localparam strip_link_pkg::err_count_t lock_err_max = 5'(lock_err_limit);
    localparam strip_link_pkg::err_count_t judge_err_max = 5'd3; // lock needs fewer errors

    logic frame_good;
    strip_link_pkg::err_count_t err_inc;

    // all four lane headers must be data or idle
    always_comb begin
        strip_link_pkg::header_t hdr;
        frame_good = 1'b1;
        for (int lane = 0; lane < strip_link_pkg::PACKETS_PER_FRAME; lane++) begin
            hdr = aligned_frame[(lane+1)*packet_width-1 -: header_width];
            if (hdr != strip_link_pkg::HEADER_DATA && hdr != strip_link_pkg::HEADER_IDLE) begin
                frame_good = 1'b0;
            end
        end
    end

    assign err_inc = err_count + 5'd1;

    always_ff @(posedge clk160) begin
        if (system_reset_r2) begin
            link_state <= strip_link_pkg::LINK_HUNT;
            align_pos  <= '0;
            good_count <= '0;
            err_count  <= '0;
            locked     <= 1'b0;
        end else begin
            case (link_state)
                strip_link_pkg::LINK_HUNT: begin
                    if (aligned_strobe) begin
                        if (frame_good) begin
                            good_count <= good_count + 9'd1;
                        end else begin
                            err_count <= err_inc;
                        end
                        link_state <= strip_link_pkg::LINK_JUDGE;
                    end
                end
                strip_link_pkg::LINK_JUDGE: begin
                    if (good_count >= good_target && err_count < judge_err_max) begin
                        link_state <= strip_link_pkg::LINK_LOCKED_WAIT;
                        locked     <= 1'b1;
                    end else if (err_count >= hunt_err_max) begin
                        // slide the window by one bit
                        if (align_pos == strip_link_pkg::MAX_ALIGN_POS) begin
                            align_pos <= '0;
                        end else begin
                            align_pos <= align_pos + 7'd1;
                        end
                        good_count <= '0;
                        err_count  <= '0;
                        link_state <= strip_link_pkg::LINK_HUNT;
                    end else if (good_count >= good_target) begin
                        // enough frames but too noisy, retry same position
                        good_count <= '0;
                        err_count  <= '0;
                        link_state <= strip_link_pkg::LINK_HUNT;
                    end else begin
                        link_state <= strip_link_pkg::LINK_HUNT;
                    end
                end
                strip_link_pkg::LINK_LOCKED_WAIT: begin
                    if (aligned_strobe) begin
                        link_state <= strip_link_pkg::LINK_LOCKED_CHECK;
                    end
                end
                strip_link_pkg::LINK_LOCKED_CHECK: begin
                    if (!frame_good && err_inc >= lock_err_max) begin
                        link_state <= strip_link_pkg::LINK_HUNT; // lost lock
                        locked     <= 1'b0;
                        good_count <= '0;
                        err_count  <= '0;
                    end else begin
                        if (!frame_good) begin
                            err_count <= err_inc;
                        end
                        link_state <= strip_link_pkg::LINK_LOCKED_WAIT;
                    end
                end
                default: begin
                    link_state <= strip_link_pkg::LINK_HUNT;
                    locked     <= 1'b0;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== logic/packet_serializer.sv ====
`timescale 1ns/10ps
`default_nettype none

module packet_serializer (
    input  wire                         clk160,
    input  wire                         system_reset_r2,
    input  wire strip_link_pkg::frame_t aligned_frame,
    input  wire                         aligned_strobe,
    output strip_link_pkg::packet_t     packet,
    output logic                        packet_valid
);

    localparam int packet_width = strip_link_pkg::PACKET_WIDTH;
    localparam int lanes = strip_link_pkg::PACKETS_PER_FRAME;
    localparam int lane_bits = $clog2(lanes);
    localparam logic [lane_bits-1:0] top_lane = lane_bits'(lanes - 1);

    strip_link_pkg::frame_t frame_r;
    logic [lane_bits-1:0] lane;
    logic [lane_bits-1:0] lane_slot;

    // lane 0 is the most significant slice
    assign lane_slot = top_lane - lane;

    always_ff @(posedge clk160) begin
        if (system_reset_r2) begin
            lane         <= '0;
            packet_valid <= 1'b0;
        end else if (aligned_strobe) begin
            lane         <= lane_bits'(1); // lane 0 goes out now
            packet_valid <= 1'b1;
        end else if (packet_valid) begin
            if (lane == '0) begin
                packet_valid <= 1'b0; // wrapped, all lanes sent
            end else begin
                lane <= lane + lane_bits'(1);
            end
        end
    end

    always_ff @(posedge clk160) begin
        if (aligned_strobe) begin
            frame_r <= aligned_frame;
            packet  <= aligned_frame[top_lane*packet_width +: packet_width];
        end else begin
            packet  <= frame_r[lane_slot*packet_width +: packet_width];
        end
    end

endmodule

`default_nettype wire

// ==== logic/strip_link_pkg.sv ====
`default_nettype none

package strip_link_pkg;

    // link geometry
    parameter int WORD_WIDTH        = 20;
    parameter int WORDS_PER_FRAME   = 6;
    parameter int PACKETS_PER_FRAME = 4;
    parameter int FRAME_WIDTH       = WORD_WIDTH * WORDS_PER_FRAME;   // 120
    parameter int PACKET_WIDTH      = FRAME_WIDTH / PACKETS_PER_FRAME; // 30
    parameter int HEADER_WIDTH      = 4;

    typedef logic [WORD_WIDTH-1:0]   word_t;
    typedef logic [FRAME_WIDTH-1:0]  frame_t;
    typedef logic [PACKET_WIDTH-1:0] packet_t;
    typedef logic [HEADER_WIDTH-1:0] header_t;

    // alignment search position, 0..119
    typedef logic [6:0] align_pos_t;

    typedef logic [8:0] good_count_t;
    typedef logic [4:0] err_count_t;

    // sync state machine encoding
    typedef enum logic [1:0] {
        LINK_HUNT         = 2'd0,
        LINK_JUDGE        = 2'd1,
        LINK_LOCKED_WAIT  = 2'd2,
        LINK_LOCKED_CHECK = 2'd3
    } link_state_t;

    // lane headers, top 4 bits of every packet
    parameter header_t HEADER_DATA = 4'b1010;
    parameter header_t HEADER_IDLE = 4'b1100;

    parameter align_pos_t MAX_ALIGN_POS = 7'd119;

endpackage

`default_nettype wire

// ==== logic/strip_link_rx.sv ====
`timescale 1ns/10ps
`default_nettype none

module strip_link_rx #(
    parameter int lock_good_count = 509, // good frames before lock
    parameter int hunt_err_limit  = 5,   // errors before stepping align_pos
    parameter int lock_err_limit  = 16   // errors that drop lock
) (
    input  wire                         clk160,
    input  wire                         system_reset_r2,
    input  wire strip_link_pkg::word_t  rx_word,
    output strip_link_pkg::packet_t     packet,
    output logic                        packet_valid,
    output logic                        link_locked,
    output strip_link_pkg::link_state_t link_state,
    output strip_link_pkg::align_pos_t  align_pos,
    output strip_link_pkg::good_count_t good_count,
    output strip_link_pkg::err_count_t  err_count,
    output logic                        disconnect
);

    strip_link_pkg::frame_t raw_frame;
    strip_link_pkg::frame_t aligned_frame;
    logic frame_strobe;
    logic aligned_strobe;
    logic locked;

    word_gatherer i_word_gatherer (
        .clk160          (clk160),
        .system_reset_r2 (system_reset_r2),
        .rx_word         (rx_word),
        .raw_frame       (raw_frame),
        .frame_strobe    (frame_strobe),
        .disconnect      (disconnect)
    );

    frame_aligner i_frame_aligner (
        .clk160          (clk160),
        .system_reset_r2 (system_reset_r2),
        .raw_frame       (raw_frame),
        .frame_strobe    (frame_strobe),
        .align_pos       (align_pos),
        .aligned_frame   (aligned_frame),
        .aligned_strobe  (aligned_strobe)
    );

    frame_sync_fsm #(
        .lock_good_count (lock_good_count),
        .hunt_err_limit  (hunt_err_limit),
        .lock_err_limit  (lock_err_limit)
    ) i_frame_sync_fsm (
        .clk160          (clk160),
        .system_reset_r2 (system_reset_r2),
        .aligned_frame   (aligned_frame),
        .aligned_strobe  (aligned_strobe),
        .align_pos       (align_pos),
        .link_state      (link_state),
        .good_count      (good_count),
        .err_count       (err_count),
        .locked          (locked)
    );

    packet_serializer i_packet_serializer (
        .clk160          (clk160),
        .system_reset_r2 (system_reset_r2),
        .aligned_frame   (aligned_frame),
        .aligned_strobe  (aligned_strobe),
        .packet          (packet),
        .packet_valid    (packet_valid)
    );

    // a stuck line cannot be trusted even if headers still look right
    assign link_locked = locked & ~disconnect;

endmodule

`default_nettype wire

// ==== logic/word_gatherer.sv ====
`timescale 1ns/10ps
`default_nettype none

module word_gatherer (
    input  wire                        clk160,
    input  wire                        system_reset_r2,
    input  wire strip_link_pkg::word_t rx_word,
    output strip_link_pkg::frame_t     raw_frame,
    output logic                       frame_strobe,
    output logic                       disconnect
);

    localparam int depth = strip_link_pkg::WORDS_PER_FRAME;
    localparam int word_width = strip_link_pkg::WORD_WIDTH;
    localparam logic [2:0] last_phase = 3'(depth - 1);
    localparam int stuck_depth = 5; // words compared for a dead line

    logic [2:0] phase;
    strip_link_pkg::word_t word_chain [depth];
    logic all_equal;

    always_ff @(posedge clk160) begin
        if (system_reset_r2) begin
            phase <= '0;
        end else if (phase == last_phase) begin
            phase <= '0;
        end else begin
            phase <= phase + 3'd1;
        end
    end

    // word_chain[0] is the newest word
    always_ff @(posedge clk160) begin
        if (system_reset_r2) begin
            for (int i = 0; i < depth; i++) begin
                word_chain[i] <= '0;
            end
        end else begin
            word_chain[0] <= rx_word;
            for (int i = 1; i < depth; i++) begin
                word_chain[i] <= word_chain[i-1];
            end
        end
    end

    // oldest word lands in the top bits
    always_ff @(posedge clk160) begin
        if (phase == last_phase) begin
            for (int i = 0; i < depth; i++) begin
                raw_frame[i*word_width +: word_width] <= word_chain[i];
            end
        end
    end

    always_comb begin
        all_equal = 1'b1;
        for (int i = 1; i < stuck_depth; i++) begin
            if (word_chain[i] != word_chain[i-1]) begin
                all_equal = 1'b0;
            end
        end
    end

    always_ff @(posedge clk160) begin
        if (system_reset_r2) begin
            frame_strobe <= 1'b0;
            disconnect   <= 1'b0;
        end else begin
            frame_strobe <= (phase == last_phase); // raw_frame fresh here
            disconnect   <= all_equal;
        end
    end

endmodule

`default_nettype wire

// ==== strip_link_rx.f ====
logic/strip_link_pkg.sv
logic/word_gatherer.sv
logic/frame_aligner.sv
logic/frame_sync_fsm.sv
logic/packet_serializer.sv
logic/strip_link_rx.sv
test/strip_link_rx_asserts.sv
test/strip_link_rx_tb.sv

// ==== test/strip_link_rx_asserts.sv ====
`timescale 1ns/10ps
`default_nettype none

module strip_link_rx_asserts (
    input wire                             clk160,
    input wire                             system_reset_r2,
    input wire strip_link_pkg::word_t      rx_word,
    input wire                             packet_valid,
    input wire                             link_locked,
    input wire strip_link_pkg::align_pos_t align_pos
);

    // four lanes per frame, then a gap
    valid_burst_length: assert property (
        @(posedge clk160) disable iff (system_reset_r2)
        $rose(packet_valid) |-> ##4 !packet_valid
    ) else $error("packet_valid high for more than four cycles");

    align_pos_range: assert property (
        @(posedge clk160) disable iff (system_reset_r2)
        align_pos <= strip_link_pkg::MAX_ALIGN_POS
    ) else $error("align_pos beyond the last legal position");

    // five equal words on the line, lock masked two edges later
    lock_masked_by_stuck_line: assert property (
        @(posedge clk160) disable iff (system_reset_r2)
        (rx_word == $past(rx_word) && rx_word == $past(rx_word, 2) &&
         rx_word == $past(rx_word, 3) && rx_word == $past(rx_word, 4))
        |-> ##2 !link_locked
    ) else $error("link_locked high while the line was stuck");

endmodule

bind strip_link_rx strip_link_rx_asserts i_asserts (.*);

`default_nettype wire

// ==== test/strip_link_rx_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module strip_link_rx_tb;

    localparam int lock_good_count = 20;
    localparam int hunt_err_limit  = 5; // DUT default, used for the time budget
    localparam int lock_cycles     = 130 * (hunt_err_limit + lock_good_count + 4) * 6;
    localparam int watchdog_cycles = 4 * lock_cycles + 5000;
    localparam int frame_width     = strip_link_pkg::FRAME_WIDTH;
    localparam int packet_width    = strip_link_pkg::PACKET_WIDTH;

    logic clk160;
    logic system_reset_r2;
    strip_link_pkg::word_t rx_word;
    strip_link_pkg::packet_t packet;
    logic packet_valid;
    logic link_locked;
    strip_link_pkg::link_state_t link_state;
    strip_link_pkg::align_pos_t align_pos;
    strip_link_pkg::good_count_t good_count;
    strip_link_pkg::err_count_t err_count;
    logic disconnect;

    int seed;
    int bit_offset;          // garbage bits ahead of frame 0
    logic [127:0] garbage;
    int next_bit;            // next stream bit to send
    int hold_words;          // words of constant zero still to send
    int corrupt_lo;
    int corrupt_hi;
    logic check_en;
    int groups_checked;
    strip_link_pkg::packet_t group [4];
    int slot;
    logic prev_valid;
    logic group_ok;
    logic synced;
    int expect_lane;         // global lane index, 4 per frame

    strip_link_rx #(
        .lock_good_count (lock_good_count)
    ) i_dut (
        .clk160          (clk160),
        .system_reset_r2 (system_reset_r2),
        .rx_word         (rx_word),
        .packet          (packet),
        .packet_valid    (packet_valid),
        .link_locked     (link_locked),
        .link_state      (link_state),
        .align_pos       (align_pos),
        .good_count      (good_count),
        .err_count       (err_count),
        .disconnect      (disconnect)
    );

    always #10 clk160 = ~clk160;

    // lane 0 in the top bits, hashed payload keeps every frame unique
    function automatic strip_link_pkg::frame_t make_frame(input int index);
        strip_link_pkg::frame_t frame;
        strip_link_pkg::header_t hdr;
        logic [31:0] mix;
        for (int lane = 0; lane < 4; lane++) begin
            mix = index * 32'h0019_660d ^ lane * 32'h3c6e_f35f;
            hdr = mix[29] ? strip_link_pkg::HEADER_IDLE : strip_link_pkg::HEADER_DATA;
            frame[(3 - lane) * packet_width +: packet_width] = {hdr, mix[25:0]};
        end
        return frame;
    endfunction

    function automatic strip_link_pkg::packet_t lane_value(input int g);
        strip_link_pkg::frame_t frame;
        frame = make_frame(g / 4);
        return frame[(3 - g % 4) * packet_width +: packet_width];
    endfunction

    function automatic strip_link_pkg::frame_t sent_frame(input int index);
        strip_link_pkg::frame_t frame;
        frame = make_frame(index);
        if (index >= corrupt_lo && index <= corrupt_hi) begin
            for (int lane = 0; lane < 4; lane++) begin
                frame[lane * packet_width + 26 +: 4] = 4'b0000; // no valid header
            end
        end
        return frame;
    endfunction

    function automatic logic stream_bit(input int n);
        strip_link_pkg::frame_t frame;
        if (n < bit_offset) begin
            return garbage[n];
        end
        frame = sent_frame((n - bit_offset) / frame_width);
        return frame[frame_width - 1 - (n - bit_offset) % frame_width];
    endfunction

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_packet(input strip_link_pkg::packet_t actual,
                                input strip_link_pkg::packet_t expected, input string name);
        if (actual !== expected) begin
            stop_with_failure($sformatf("Mismatch at %0t: %s = %h, expected %h",
                                        $time, name, actual, expected));
        end
    endtask

    task automatic check_state(input strip_link_pkg::link_state_t actual,
                               input strip_link_pkg::link_state_t expected, input string name);
        if (actual !== expected) begin
            stop_with_failure($sformatf("Mismatch at %0t: %s = %0d, expected %0d",
                                        $time, name, actual, expected));
        end
    endtask

    task automatic check_pos(input strip_link_pkg::align_pos_t actual,
                             input strip_link_pkg::align_pos_t expected, input string name);
        if (actual !== expected) begin
            stop_with_failure($sformatf("Mismatch at %0t: %s = %0d, expected %0d",
                                        $time, name, actual, expected));
        end
    endtask

    task automatic check_good_count(input strip_link_pkg::good_count_t actual,
                                    input strip_link_pkg::good_count_t expected,
                                    input string name);
        if (actual !== expected) begin
            stop_with_failure($sformatf("Mismatch at %0t: %s = %0d, expected %0d",
                                        $time, name, actual, expected));
        end
    endtask

    task automatic check_err_count(input strip_link_pkg::err_count_t actual,
                                   input strip_link_pkg::err_count_t expected,
                                   input string name);
        if (actual !== expected) begin
            stop_with_failure($sformatf("Mismatch at %0t: %s = %0d, expected %0d",
                                        $time, name, actual, expected));
        end
    endtask

    task automatic check_flag(input logic actual, input logic expected, input string name);
        if (actual !== expected) begin
            stop_with_failure($sformatf("Mismatch at %0t: %s = %b, expected %b",
                                        $time, name, actual, expected));
        end
    endtask

    // reset for 8 cycles, reset values checked just before release
    task automatic apply_reset();
        system_reset_r2 = 1'b1;
        repeat (8) @(negedge clk160);
        check_flag(packet_valid, 1'b0, "packet_valid");
        check_flag(link_locked, 1'b0, "link_locked");
        check_state(link_state, strip_link_pkg::LINK_HUNT, "link_state");
        check_pos(align_pos, 7'd0, "align_pos");
        system_reset_r2 = 1'b0;
    endtask

    task automatic wait_lock_level(input logic level, input int limit);
        int cycles;
        cycles = 0;
        while (link_locked !== level) begin
            @(negedge clk160);
            cycles++;
            if (cycles > limit) begin
                stop_with_failure($sformatf("link_locked did not go to %b within %0d cycles",
                                            level, limit));
            end
        end
    endtask

    task automatic wait_groups(input int n);
        int target;
        int cycles;
        target = groups_checked + n;
        cycles = 0;
        while (groups_checked < target) begin
            @(negedge clk160);
            cycles++;
            if (cycles > n * 18 + 60) begin
                stop_with_failure("too few packet groups arrived while the link was locked");
            end
        end
    endtask

    // find the group in the sent lane stream once, then expect consecutive lanes
    task automatic compare_group();
        int cur;
        logic found;
        if (!synced) begin
            cur = (next_bit - bit_offset) / frame_width;
            found = 1'b0;
            for (int idx = cur; idx >= 0 && idx >= cur - 10 && !found; idx--) begin
                for (int r = 0; r < 4 && !found; r++) begin
                    if (group[0] === lane_value(4 * idx + r) &&
                        group[1] === lane_value(4 * idx + r + 1) &&
                        group[2] === lane_value(4 * idx + r + 2) &&
                        group[3] === lane_value(4 * idx + r + 3)) begin
                        found = 1'b1;
                        expect_lane = 4 * idx + r;
                    end
                end
            end
            if (!found) begin
                stop_with_failure("received packet group matches none of the recent frames");
            end
            synced = 1'b1;
        end
        for (int k = 0; k < 4; k++) begin
            check_packet(group[k], lane_value(expect_lane + k), "packet");
        end
        expect_lane = expect_lane + 4;
        groups_checked++;
    endtask

    // stimulus, one word per falling edge
    always @(negedge clk160) begin
        if (hold_words > 0) begin
            rx_word = '0;
            hold_words = hold_words - 1;
        end else begin
            for (int i = 0; i < 20; i++) begin
                rx_word[19 - i] = stream_bit(next_bit + i); // earliest bit in the msb
            end
            next_bit = next_bit + 20;
        end
    end

    always @(negedge clk160) begin
        if (!link_locked || !check_en) begin
            synced = 1'b0;
        end
        if (packet_valid) begin
            if (!prev_valid) begin
                slot     = 0;
                group_ok = link_locked && check_en;
            end
            if (slot >= 4) begin
                stop_with_failure("packet_valid stayed high past four packets");
            end
            group[slot] = packet;
            slot = slot + 1;
            if (slot == 4) begin
                if (group_ok && link_locked && check_en) begin
                    compare_group();
                end else begin
                    synced = 1'b0;
                end
            end
        end
        prev_valid = packet_valid;
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk160);
        stop_with_failure("watchdog expired before the test sequence completed");
    end

    initial begin
        clk160          = 1'b0;
        system_reset_r2 = 1'b1;
        rx_word         = '0;
        seed            = 32'h9dbb_42cf;
        bit_offset      = $unsigned($random(seed)) % 120;
        garbage         = {$random(seed), $random(seed), $random(seed), $random(seed)};
        next_bit        = 0;
        hold_words      = 0;
        corrupt_lo      = 1;
        corrupt_hi      = 0;
        check_en        = 1'b0;
        groups_checked  = 0;
        slot            = 0;
        prev_valid      = 1'b0;
        group_ok        = 1'b0;
        synced          = 1'b0;
        expect_lane     = 0;

        apply_reset();
        wait_lock_level(1'b1, lock_cycles);
        check_good_count(good_count, lock_good_count, "good_count"); // lock on the target
        check_en = 1'b1;
        wait_groups(8);

        // 16 frames with broken headers drop the lock
        check_en   = 1'b0;
        corrupt_lo = (next_bit - bit_offset) / frame_width + 3;
        corrupt_hi = corrupt_lo + 15;
        wait_lock_level(1'b0, 40 * 6);
        check_state(link_state, strip_link_pkg::LINK_HUNT, "link_state");
        check_good_count(good_count, '0, "good_count"); // both counters clear on loss
        check_err_count(err_count, '0, "err_count");
        wait_lock_level(1'b1, lock_cycles);
        check_good_count(good_count, lock_good_count, "good_count");
        check_en = 1'b1;
        wait_groups(8);

        // stuck line
        check_en   = 1'b0;
        hold_words = 48; // whole frames, stream phase kept
        while (!disconnect) begin
            @(negedge clk160);
            if (hold_words == 0) begin
                stop_with_failure("disconnect did not rise while rx_word was constant");
            end
        end
        while (hold_words > 0) begin
            @(negedge clk160);
            if (disconnect) begin
                check_flag(link_locked, 1'b0, "link_locked");
            end
        end
        repeat (60) @(negedge clk160); // flush frames holding zeros
        wait_lock_level(1'b1, lock_cycles);
        check_good_count(good_count, lock_good_count, "good_count"); // untouched while locked
        check_en = 1'b1;
        wait_groups(8);

        // reset in mid-run
        check_en = 1'b0;
        apply_reset();
        wait_lock_level(1'b1, lock_cycles);
        check_good_count(good_count, lock_good_count, "good_count");
        check_en = 1'b1;
        wait_groups(8);

        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire
